/* common/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of one program memory word.
`define CORE_WORD_WIDTH 12

// Width of the accumulator, the registers and the operands.
`define CORE_DATA_WIDTH 8

// Width of the program counter and of the fetch address.
`define CORE_PC_WIDTH 8

// Register address width. Four bits give sixteen registers.
`define CORE_REG_ADDR_WIDTH 4

`endif

/* common/coreTypes.sv */
`default_nettype none

package coreTypes;

    // The two phases an instruction steps through.
    typedef enum logic {
        ADDRESS     = 1'b0,
        INSTRUCTION = 1'b1
    } coreMode;

    // Time states inside a phase. The counter wraps after T6.
    typedef enum logic [2:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5,
        T6 = 3'd6
    } timeStep;

    // Opcodes found in bits 11 to 6 of an instruction word.
    typedef enum logic [5:0] {
        NOP  = 6'd0,
        LDI  = 6'd1,  // Immediate load.
        ADDI = 6'd2,  // Immediate add.
        SUBI = 6'd3,  // Immediate subtract.
        ADD  = 6'd4,
        SUB  = 6'd5,
        AND  = 6'd6,
        XOR  = 6'd7,
        LDR  = 6'd8,  // Load accumulator from a register.
        STA  = 6'd9,  // Store accumulator into a register.
        HALT = 6'd10
    } opcode;

endpackage

`default_nettype wire

/* sequencer/instructionDecoder.sv */
`default_nettype none
`include "core_settings.svh"

module instructionDecoder (
    input  wire logic [`CORE_WORD_WIDTH-1:0]     fetchData,
    input  wire coreTypes::opcode                currentInstruction,
    input  wire coreTypes::coreMode              mode,
    input  wire coreTypes::timeStep              timeState,
    output coreTypes::opcode                     decodedInstruction,
    output logic [`CORE_REG_ADDR_WIDTH-1:0]      decodedAddress,
    output logic                                 noAddressing,
    output logic                                 endAddressing,
    output logic                                 getInstruction,
    output logic                                 operandLoad,
    output logic                                 writeEnable,
    output logic                                 halted
);

    logic [5:0] rawOpcode;
    logic       isImmediate;
    logic       inInstruction;

    assign rawOpcode      = fetchData[`CORE_WORD_WIDTH-1:`CORE_WORD_WIDTH-6];
    assign decodedAddress = fetchData[`CORE_REG_ADDR_WIDTH-1:0];

    // Codes above HALT have no meaning and run as NOP.
    always_comb begin
        if (rawOpcode <= coreTypes::HALT) begin
            decodedInstruction = coreTypes::opcode'(rawOpcode);
        end else begin
            decodedInstruction = coreTypes::NOP;
        end
    end

    assign isImmediate = (currentInstruction == coreTypes::LDI)  ||
                         (currentInstruction == coreTypes::ADDI) ||
                         (currentInstruction == coreTypes::SUBI);
    assign inInstruction = (mode == coreTypes::INSTRUCTION);

    assign noAddressing  = !isImmediate;
    assign endAddressing = isImmediate && !inInstruction && (timeState == coreTypes::T0);
    assign operandLoad   = endAddressing; // The operand word is on the bus right now.
    assign halted        = (currentInstruction == coreTypes::HALT);

    // NOP finishes at T1, everything else at T2. HALT never finishes.
    always_comb begin
        getInstruction = 1'b0;
        if (inInstruction) begin
            if (currentInstruction == coreTypes::NOP) begin
                getInstruction = (timeState == coreTypes::T1);
            end else if (currentInstruction != coreTypes::HALT) begin
                getInstruction = (timeState == coreTypes::T2);
            end
        end
    end

    assign writeEnable = inInstruction && (timeState == coreTypes::T2) &&
                         (currentInstruction != coreTypes::NOP) &&
                         (currentInstruction != coreTypes::HALT);

endmodule

`default_nettype wire

/* sequencer/timingGenerator.sv */
`default_nettype none
`include "core_settings.svh"

module timingGenerator (
    input  wire logic                            clk,
    input  wire logic                            nrst,
    input  wire logic                            ready,
    input  wire logic                            noAddressing,
    input  wire logic                            getInstruction,
    input  wire logic                            endAddressing,
    input  wire coreTypes::opcode                decodedInstruction,
    input  wire logic [`CORE_REG_ADDR_WIDTH-1:0] decodedAddress,
    output coreTypes::opcode                     currentInstruction,
    output logic [`CORE_REG_ADDR_WIDTH-1:0]      currentAddress,
    output coreTypes::timeStep                   timeState,
    output coreTypes::coreMode                   mode
);

    coreTypes::coreMode              nextMode;
    coreTypes::timeStep              nextTime;
    coreTypes::opcode                nextInstruction;
    logic [`CORE_REG_ADDR_WIDTH-1:0] nextAddress;

    always_comb begin : timeNext
        if (endAddressing) begin
            nextMode = coreTypes::INSTRUCTION; // Addressing is over, run the instruction.
            nextTime = coreTypes::T0;
        end else if (getInstruction) begin
            nextMode = coreTypes::ADDRESS; // Start over with the next word.
            nextTime = coreTypes::T0;
        end else begin
            nextMode = mode;
            case (timeState)
                coreTypes::T0: nextTime = coreTypes::T1;
                coreTypes::T1: nextTime = coreTypes::T2;
                coreTypes::T2: nextTime = coreTypes::T3;
                coreTypes::T3: nextTime = coreTypes::T4;
                coreTypes::T4: nextTime = coreTypes::T5;
                coreTypes::T5: nextTime = coreTypes::T6;
                default:       nextTime = coreTypes::T0;
            endcase
        end

        // Opcodes without an operand skip straight into the instruction phase.
        // The time state keeps counting, so they land on T1.
        if ((mode == coreTypes::ADDRESS) && noAddressing) begin
            nextMode = coreTypes::INSTRUCTION;
        end

        if (!ready) begin
            nextMode = mode;
            nextTime = timeState;
        end
    end

    // The decoder follows fetchData all the time, so the opcode is only taken
    // on the last cycle of the running instruction.
    always_comb begin : opcodeNext
        nextInstruction = currentInstruction;
        nextAddress     = currentAddress;
        if (getInstruction && ready) begin
            nextInstruction = decodedInstruction;
            nextAddress     = decodedAddress;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin : stateRegs
        if (!nrst) begin
            mode      <= coreTypes::ADDRESS;
            timeState <= coreTypes::T0;
        end else begin
            mode      <= nextMode;
            timeState <= nextTime;
        end
    end

    // Reset loads a NOP, which fetches word 0 two cycles later.
    always_ff @(posedge clk or negedge nrst) begin : opcodeRegs
        if (!nrst) begin
            currentInstruction <= coreTypes::NOP;
            currentAddress     <= '0;
        end else begin
            currentInstruction <= nextInstruction;
            currentAddress     <= nextAddress;
        end
    end

endmodule

`default_nettype wire

/* datapath/aluExecute.sv */
`default_nettype none
`include "core_settings.svh"

module aluExecute (
    input  wire logic                        clk,
    input  wire logic                        nrst,
    input  wire logic                        ready,
    input  wire logic                        operandLoad,
    input  wire logic [`CORE_WORD_WIDTH-1:0] fetchData,
    input  wire coreTypes::opcode            currentInstruction,
    input  wire logic [`CORE_DATA_WIDTH-1:0] accumulator,
    input  wire logic [`CORE_DATA_WIDTH-1:0] registerData,
    output logic [`CORE_DATA_WIDTH-1:0]      aluResult
);

    logic [`CORE_DATA_WIDTH-1:0] operand;

    // The operand word follows an immediate opcode. Only its low byte carries data.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            operand <= '0;
        end else if (operandLoad && ready) begin
            operand <= fetchData[`CORE_DATA_WIDTH-1:0];
        end
    end

    // All sums and differences wrap modulo 256.
    always_comb begin
        case (currentInstruction)
            coreTypes::LDI:  aluResult = operand;
            coreTypes::ADDI: aluResult = accumulator + operand;
            coreTypes::SUBI: aluResult = accumulator - operand;
            coreTypes::ADD:  aluResult = accumulator + registerData;
            coreTypes::SUB:  aluResult = accumulator - registerData;
            coreTypes::AND:  aluResult = accumulator & registerData;
            coreTypes::XOR:  aluResult = accumulator ^ registerData;
            coreTypes::LDR:  aluResult = registerData;
            coreTypes::STA:  aluResult = accumulator; // Value that goes to the register.
            default:         aluResult = accumulator;
        endcase
    end

endmodule

`default_nettype wire

/* datapath/resultCommit.sv */
`default_nettype none
`include "core_settings.svh"

module resultCommit (
    input  wire logic                            clk,
    input  wire logic                            nrst,
    input  wire logic                            ready,
    input  wire logic                            getInstruction,
    input  wire logic                            operandLoad,
    input  wire logic                            writeEnable,
    input  wire coreTypes::opcode                currentInstruction,
    input  wire logic [`CORE_REG_ADDR_WIDTH-1:0] currentAddress,
    input  wire logic [`CORE_DATA_WIDTH-1:0]     aluResult,
    output logic [`CORE_PC_WIDTH-1:0]            programCounter,
    output logic [`CORE_DATA_WIDTH-1:0]          accumulator,
    output logic [`CORE_DATA_WIDTH-1:0]          registerData,
    output logic                                 resultValid,
    output logic [`CORE_DATA_WIDTH-1:0]          resultValue
);

    logic [`CORE_DATA_WIDTH-1:0] registers [0:(1 << `CORE_REG_ADDR_WIDTH) - 1];
    logic                        commitNow;
    logic                        isStore;

    assign commitNow    = writeEnable && ready;
    assign isStore      = (currentInstruction == coreTypes::STA);
    assign registerData = registers[currentAddress]; // Register operand of the running opcode.

    // The fetch address steps past every opcode word and every operand word.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            programCounter <= '0;
        end else if (ready && (getInstruction || operandLoad)) begin
            programCounter <= programCounter + 1'b1;
        end
    end

    // STA goes to the register file, every other result to the accumulator.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            accumulator <= '0;
            registers   <= '{default: '0};
        end else if (commitNow) begin
            if (isStore) begin
                registers[currentAddress] <= aluResult;
            end else begin
                accumulator <= aluResult;
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            resultValid <= 1'b0;
            resultValue <= '0;
        end else begin
            resultValid <= commitNow; // One pulse for each writeback.
            if (commitNow) begin
                resultValue <= aluResult;
            end
        end
    end

endmodule

`default_nettype wire

/* source/accumulatorCore.sv */
`default_nettype none
`include "core_settings.svh"

module accumulatorCore (
    input  wire logic                        clk,
    input  wire logic                        nrst,
    input  wire logic                        ready,
    input  wire logic [`CORE_WORD_WIDTH-1:0] fetchData,
    output logic [`CORE_PC_WIDTH-1:0]        fetchAddress,
    output logic                             resultValid,
    output logic [`CORE_DATA_WIDTH-1:0]      resultValue,
    output logic                             halted
);

    coreTypes::opcode                decodedInstruction;
    coreTypes::opcode                currentInstruction;
    coreTypes::coreMode              mode;
    coreTypes::timeStep              timeState;
    logic [`CORE_REG_ADDR_WIDTH-1:0] decodedAddress;
    logic [`CORE_REG_ADDR_WIDTH-1:0] currentAddress;
    logic                            noAddressing;
    logic                            endAddressing;
    logic                            getInstruction;
    logic                            operandLoad;
    logic                            writeEnable;
    logic [`CORE_DATA_WIDTH-1:0]     aluResult;
    logic [`CORE_DATA_WIDTH-1:0]     accumulator;
    logic [`CORE_DATA_WIDTH-1:0]     registerData;
    logic [`CORE_PC_WIDTH-1:0]       programCounter;

    assign fetchAddress = programCounter;

    instructionDecoder decoder (
        .fetchData(fetchData),
        .currentInstruction(currentInstruction),
        .mode(mode),
        .timeState(timeState),
        .decodedInstruction(decodedInstruction),
        .decodedAddress(decodedAddress),
        .noAddressing(noAddressing),
        .endAddressing(endAddressing),
        .getInstruction(getInstruction),
        .operandLoad(operandLoad),
        .writeEnable(writeEnable),
        .halted(halted)
    );

    timingGenerator timing (
        .clk(clk),
        .nrst(nrst),
        .ready(ready),
        .noAddressing(noAddressing),
        .getInstruction(getInstruction),
        .endAddressing(endAddressing),
        .decodedInstruction(decodedInstruction),
        .decodedAddress(decodedAddress),
        .currentInstruction(currentInstruction),
        .currentAddress(currentAddress),
        .timeState(timeState),
        .mode(mode)
    );

    aluExecute alu (
        .clk(clk),
        .nrst(nrst),
        .ready(ready),
        .operandLoad(operandLoad),
        .fetchData(fetchData),
        .currentInstruction(currentInstruction),
        .accumulator(accumulator),
        .registerData(registerData),
        .aluResult(aluResult)
    );

    resultCommit commit (
        .clk(clk),
        .nrst(nrst),
        .ready(ready),
        .getInstruction(getInstruction),
        .operandLoad(operandLoad),
        .writeEnable(writeEnable),
        .currentInstruction(currentInstruction),
        .currentAddress(currentAddress),
        .aluResult(aluResult),
        .programCounter(programCounter),
        .accumulator(accumulator),
        .registerData(registerData),
        .resultValid(resultValid),
        .resultValue(resultValue)
    );

endmodule

`default_nettype wire

/* dv/coreChecker.sv */
`default_nettype none
`include "core_settings.svh"

module coreChecker (
    input wire logic                        clk,
    input wire logic                        nrst,
    input wire logic                        ready,
    input wire logic                        resultValid,
    input wire logic [`CORE_DATA_WIDTH-1:0] resultValue,
    input wire logic                        halted
);

    logic [`CORE_DATA_WIDTH-1:0] expQ[$];
    logic [`CORE_DATA_WIDTH-1:0] expected;
    logic                        readyBefore;
    logic                        haltSeen;
    int                          testErrors;
    int                          testResults;
    int                          totalErrors;
    int                          totalResults;
    int                          testsDone;

    function automatic void expectValue(input logic [`CORE_DATA_WIDTH-1:0] value);
        expQ.push_back(value);
    endfunction

    task automatic startTest();
        expQ.delete();
        testErrors  = 0;
        testResults = 0;
    endtask

    task automatic reportError(input string msg);
        $display("ERR at time %0t: %s", $time, msg);
        testErrors++;
    endtask

    // Leftover predictions at the end of a test mean results went missing.
    task automatic finishTest(input string name);
        if (expQ.size() != 0) begin
            $display("Test %s ended with %0d expected results never produced", name, expQ.size());
            testErrors++;
        end
        $display("Test %s done: %0d results, %0d errors", name, testResults, testErrors);
        totalErrors  += testErrors;
        totalResults += testResults;
        testsDone++;
    endtask

    initial begin
        totalErrors  = 0;
        totalResults = 0;
        testsDone    = 0;
        testErrors   = 0;
        testResults  = 0;
    end

    always @(posedge clk) begin
        if (!nrst) begin
            readyBefore <= 1'b0;
            haltSeen    <= 1'b0;
        end else begin
            if (resultValid) begin
                if (!readyBefore) begin
                    reportError("resultValid pulse after a stalled cycle");
                end else if (haltSeen) begin
                    reportError("resultValid pulse after halted");
                end else if (expQ.size() == 0) begin
                    reportError($sformatf("unexpected result %0h", resultValue));
                end else begin
                    expected = expQ.pop_front();
                    testResults++;
                    if (resultValue !== expected) begin
                        reportError($sformatf("resultValue %0h, expected %0h",
                                              resultValue, expected));
                    end
                end
            end
            // The last result lands in the same cycle that halted rises.
            if (halted && !haltSeen) begin
                haltSeen <= 1'b1;
                if (expQ.size() != 0) begin
                    $display("Core halted at time %0t with %0d results still pending",
                             $time, expQ.size());
                    testErrors++;
                end
            end
            readyBefore <= ready;
        end
    end

endmodule

`default_nettype wire

/* dv/accumulatorCore_props.sv */
`default_nettype none

module sequencerProps (
    input wire logic               clk,
    input wire logic               nrst,
    input wire logic               ready,
    input wire logic               getInstruction,
    input wire logic               endAddressing,
    input wire coreTypes::coreMode mode,
    input wire coreTypes::timeStep timeState,
    input wire coreTypes::opcode   currentInstruction
);

    // An instruction cannot end while its addressing phase is still closing.
    assert property (@(posedge clk) disable iff (!nrst) !(getInstruction && endAddressing))
        else $error("getInstruction and endAddressing high together");

    assert property (@(posedge clk) disable iff (!nrst)
                     !ready |=> $stable(mode) && $stable(timeState) &&
                                $stable(currentInstruction))
        else $error("Sequencer state moved while ready was low");

    assert property (@(posedge clk) $rose(nrst) |->
                     (mode == coreTypes::ADDRESS) && (timeState == coreTypes::T0))
        else $error("Sequencer not at ADDRESS T0 after reset");

endmodule

bind timingGenerator sequencerProps seqProps (.*);

`default_nettype wire

/* dv/accumulatorCore_tb.sv */
`default_nettype none
`include "core_settings.svh"

module accumulatorCore_tb;

    logic                        clk;
    logic                        nrst;
    logic                        ready;
    logic [`CORE_WORD_WIDTH-1:0] fetchData;
    logic [`CORE_PC_WIDTH-1:0]   fetchAddress;
    logic                        resultValid;
    logic [`CORE_DATA_WIDTH-1:0] resultValue;
    logic                        halted;

    logic [`CORE_WORD_WIDTH-1:0] progMem [0:255];
    integer                      seed;
    logic                        stallMode;
    int                          progLength;

    accumulatorCore uut (
        .clk(clk), .nrst(nrst), .ready(ready), .fetchData(fetchData),
        .fetchAddress(fetchAddress), .resultValid(resultValid),
        .resultValue(resultValue), .halted(halted)
    );

    coreChecker chk (
        .clk(clk), .nrst(nrst), .ready(ready), .resultValid(resultValid),
        .resultValue(resultValue), .halted(halted)
    );

    assign fetchData = progMem[fetchAddress]; // Asynchronous program memory.

    always #2 clk = !clk;

    // Ready changes just after each edge, at random in stall mode.
    always @(posedge clk) begin
        #1;
        ready <= stallMode ? (($random(seed) & 3) != 0) : 1'b1;
    end

    function automatic logic [11:0] makeWord(input logic [5:0] op, input logic [3:0] addr);
        return {op, 2'b00, addr};
    endfunction

    task automatic fillMemory();
        for (int a = 0; a < 256; a++) begin
            progMem[a] = {6'd10, a[5:0] ^ {4'b0, a[7:6]}}; // HALT words everywhere.
        end
        progLength = 0;
    endtask

    task automatic putWord(input logic [11:0] word);
        progMem[progLength] = word;
        progLength++;
    endtask

    // Builds count instructions from the opcodes lo to hi, then HALT.
    task automatic buildProgram(input int count, input int lo, input int hi);
        int          op;
        logic [31:0] rnd;
        fillMemory();
        for (int i = 0; i < count; i++) begin
            op  = lo + ({$random(seed)} % (hi - lo + 1));
            rnd = $random(seed);
            putWord(makeWord(op[5:0], rnd[3:0]));
            if (op >= 1 && op <= 3) begin
                rnd = $random(seed);
                putWord(rnd[11:0]); // Operand word, only bits 7 to 0 count.
            end
        end
        putWord(makeWord(6'd10, 4'd0));
    endtask

    // Fills every register first, then mixes the register opcodes.
    task automatic buildRegisterProgram();
        int          op;
        logic [31:0] rnd;
        fillMemory();
        for (int r = 0; r < 16; r++) begin
            rnd = $random(seed);
            putWord(makeWord(6'd2, 4'd0));
            putWord(rnd[11:0]);
            putWord(makeWord(6'd9, r[3:0]));
        end
        for (int i = 0; i < 40; i++) begin
            op  = 4 + ({$random(seed)} % 6);
            rnd = $random(seed);
            putWord(makeWord(op[5:0], rnd[3:0]));
        end
        putWord(makeWord(6'd10, 4'd0));
    endtask

    // The reference walks the program and queues every expected result.
    function automatic void predictResults();
        logic [7:0] acc;
        logic [7:0] regs [0:15];
        logic [7:0] operand;
        logic [5:0] op;
        logic [3:0] ra;
        int         pc;
        acc = 0;
        pc  = 0;
        for (int r = 0; r < 16; r++) regs[r] = 0;
        while (pc < 255) begin
            op = progMem[pc][11:6];
            ra = progMem[pc][3:0];
            operand = progMem[pc + 1][7:0];
            if (op > 6'd10) op = 6'd0; // Unknown codes behave as NOP.
            if (op == 6'd10) break;
            pc += (op >= 1 && op <= 3) ? 2 : 1;
            case (op)
                6'd1: acc = operand;
                6'd2: acc = acc + operand;
                6'd3: acc = acc - operand;
                6'd4: acc = acc + regs[ra];
                6'd5: acc = acc - regs[ra];
                6'd6: acc = acc & regs[ra];
                6'd7: acc = acc ^ regs[ra];
                6'd8: acc = regs[ra];
                6'd9: regs[ra] = acc;
                default: ;
            endcase
            if (op != 6'd0) chk.expectValue(acc);
        end
    endfunction

    task automatic runProgram(input string name, input logic stall);
        int cycles;
        int limit;
        limit = 2 * 4 * progLength + 50;
        chk.startTest();
        predictResults();
        @(posedge clk);
        #1;
        nrst      = 1'b0;
        stallMode = stall;
        repeat (8) @(posedge clk);
        #1;
        nrst   = 1'b1;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: test %s did not halt within %0d cycles", name, limit);
            $display("Finished with errors");
            $finish;
        end else begin
            repeat (30) @(posedge clk); // Nothing may come out of a halted core.
            chk.finishTest(name);
        end
    endtask

    initial begin
        clk       = 1'b0;
        nrst      = 1'b0;
        ready     = 1'b0;
        stallMode = 1'b0;
        seed      = 32'hfa2e;

        buildProgram(10, 0, 0);
        putWord(makeWord(6'd9, 4'd5)); // A store here would show up as a result.
        runProgram("nop_only", 1'b0);

        buildProgram(24, 1, 3);
        runProgram("immediate", 1'b0);

        buildRegisterProgram();
        runProgram("register", 1'b0);

        buildProgram(40, 0, 11);
        runProgram("random_ready_high", 1'b0);
        runProgram("random_stalled", 1'b1);

        $display("Tests: %0d, results checked: %0d, errors: %0d",
                 chk.testsDone, chk.totalResults, chk.totalErrors);
        if (chk.totalErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/coreTypes.sv
sequencer/instructionDecoder.sv
sequencer/timingGenerator.sv
datapath/aluExecute.sv
datapath/resultCommit.sv
source/accumulatorCore.sv
dv/coreChecker.sv
dv/accumulatorCore_props.sv
dv/accumulatorCore_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the accumulator core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module accumulatorCore_tb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
